// ==== hdl/alu.sv ====
`default_nettype none

module alu (
	input  isa_pkg::alu_op_t i_op,
	input  isa_pkg::byte_t   i_a,
	input  isa_pkg::byte_t   i_b,
	input  logic             i_cy,
	output isa_pkg::byte_t   o_res,
	output logic             o_cy
);
	import isa_pkg::*;

	logic       cin; // carry only for ADC and SBB
	logic [8:0] wide;

	assign cin = i_cy && (i_op == ADC || i_op == SBB);

	always_comb begin
		wide  = 9'd0;
		o_res = 8'h00;
		o_cy  = 1'b0; // logic ops clear carry
		case (i_op)
			ADD, ADC: begin
				wide  = {1'b0, i_a} + {1'b0, i_b} + {8'd0, cin};
				o_res = wide[7:0];
				o_cy  = wide[8];
			end
			SUB, SBB, CMP: begin
				wide  = {1'b0, i_a} - {1'b0, i_b} - {8'd0, cin};
				o_res = wide[7:0];
				o_cy  = wide[8]; // borrow
			end
			ANA: o_res = i_a & i_b;
			XRA: o_res = i_a ^ i_b;
			ORA: o_res = i_a | i_b;
			default: o_res = i_a;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/bus_cycle_ctrl.sv ====
`default_nettype none

module bus_cycle_ctrl (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 i_ready,
	input  logic                 i_second,
	input  bus_pkg::cycle_kind_t i_second_kind,
	input  logic                 i_halt,
	output bus_pkg::t_state_t    o_state,
	output bus_pkg::cycle_kind_t o_kind,
	output bus_pkg::bus_stat_t   o_stat,
	output logic                 o_ale,
	output logic                 o_rd_n,
	output logic                 o_wr_n,
	output logic                 o_ir_load,
	output logic                 o_exec
);
	import bus_pkg::*;

	t_state_t    state_q;
	t_state_t    state_d;
	cycle_kind_t kind_q;
	cycle_kind_t kind_d;
	logic        pend_q; // second machine cycle in flight
	logic        pend_d;
	logic        strobe; // T2 through T3

	//----------------------------------------------------------------------
	// next state
	//----------------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		kind_d  = kind_q;
		pend_d  = pend_q;
		case (state_q)
			TR: begin
				state_d = T1;
				kind_d  = OF;
			end
			T1: state_d = T2;
			T2: state_d = i_ready ? T3 : TW;
			TW: state_d = i_ready ? T3 : TW;
			T3: begin
				if (pend_q) begin // instruction done, next fetch
					state_d = T1;
					kind_d  = OF;
					pend_d  = 1'b0;
				end else begin
					state_d = T4;
				end
			end
			T4: begin
				state_d = T1;
				kind_d  = OF;
				if (i_halt) begin
					state_d = TT;
					kind_d  = BI;
				end else if (i_second) begin
					kind_d = i_second_kind;
					pend_d = 1'b1;
				end
			end
			TT: state_d = TT; // only reset leaves halt
			default: state_d = TR;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q <= TR;
			kind_q  <= OF;
			pend_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			kind_q  <= kind_d;
			pend_q  <= pend_d;
		end
	end

	//----------------------------------------------------------------------
	// pins
	//----------------------------------------------------------------------
	assign strobe = (state_q == T2) || (state_q == TW) || (state_q == T3);
	assign o_ale  = (state_q == T1);
	assign o_rd_n = !(strobe && (kind_q == OF || kind_q == MR));
	assign o_wr_n = !(strobe && kind_q == MW);

	always_comb begin
		case (kind_q)
			OF: o_stat = STAT_OF;
			MR: o_stat = STAT_MR;
			MW: o_stat = STAT_MW;
			default: o_stat = STAT_HALT;
		endcase
	end

	assign o_ir_load = (state_q == T3) && (kind_q == OF);
	assign o_exec    = ((state_q == T4) && !i_second) || ((state_q == T3) && pend_q);
	assign o_state   = state_q;
	assign o_kind    = kind_q;

	a_strobe_excl: assert property (@(posedge clk) disable iff (rst)
		!(!o_rd_n && !o_wr_n));

	// ALE is a single T1 clock and the strobe state follows
	a_ale_t1: assert property (@(posedge clk) disable iff (rst)
		o_ale |=> !o_ale && state_q == T2);

	a_tw_entry: assert property (@(posedge clk) disable iff (rst)
		state_q == TW |-> ($past(state_q) == T2 || $past(state_q) == TW));

endmodule

`default_nettype wire

// ==== hdl/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

	// one-hot T-states
	typedef enum logic [6:0] {
		TR = 7'b0000001, // reset
		T1 = 7'b0000010, // address and ALE
		T2 = 7'b0000100, // strobe low
		TW = 7'b0001000, // wait on READY
		T3 = 7'b0010000, // data sampled
		T4 = 7'b0100000, // decode of fetched opcode
		TT = 7'b1000000  // halted
	} t_state_t;

	typedef enum logic [1:0] {OF, MR, MW, BI} cycle_kind_t;

	typedef struct packed {
		logic iom;
		logic s1;
		logic s0;
	} bus_stat_t;

	localparam bus_stat_t STAT_OF   = 3'b011;
	localparam bus_stat_t STAT_MR   = 3'b010;
	localparam bus_stat_t STAT_MW   = 3'b001;
	localparam bus_stat_t STAT_HALT = 3'b000;

endpackage

`default_nettype wire

// ==== hdl/cpu85_top.sv ====
`default_nettype none

module cpu85_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_ready,
	input  isa_pkg::byte_t     i_din,
	output isa_pkg::addr_t     o_addr,
	output isa_pkg::byte_t     o_dout,
	output bus_pkg::bus_stat_t o_stat,
	output logic               o_ale,
	output logic               o_rd_n,
	output logic               o_wr_n
);
	import isa_pkg::*;
	import bus_pkg::*;

	t_state_t    state;
	cycle_kind_t kind;
	cycle_kind_t second_kind;
	ctrl_word_t  ctrl;
	byte_t       ir;
	logic        ir_load;
	logic        exec;
	logic        second;
	logic        halt;

	bus_cycle_ctrl u_bus (
		.clk          (clk),
		.rst          (rst),
		.i_ready      (i_ready),
		.i_second     (second),
		.i_second_kind(second_kind),
		.i_halt       (halt),
		.o_state      (state),
		.o_kind       (kind),
		.o_stat       (o_stat),
		.o_ale        (o_ale),
		.o_rd_n       (o_rd_n),
		.o_wr_n       (o_wr_n),
		.o_ir_load    (ir_load),
		.o_exec       (exec)
	);

	instr_decode u_dec (
		.i_ir         (ir),
		.o_ctrl       (ctrl),
		.o_second     (second),
		.o_second_kind(second_kind),
		.o_halt       (halt)
	);

	datapath u_dp (
		.clk      (clk),
		.rst      (rst),
		.i_state  (state),
		.i_kind   (kind),
		.i_ir_load(ir_load),
		.i_exec   (exec),
		.i_ctrl   (ctrl),
		.i_din    (i_din),
		.o_ir     (ir),
		.o_addr   (o_addr),
		.o_dout   (o_dout)
	);

endmodule

`default_nettype wire

// ==== hdl/datapath.sv ====
`default_nettype none

module datapath (
	input  logic                 clk,
	input  logic                 rst,
	input  bus_pkg::t_state_t    i_state,
	input  bus_pkg::cycle_kind_t i_kind,
	input  logic                 i_ir_load,
	input  logic                 i_exec,
	input  isa_pkg::ctrl_word_t  i_ctrl,
	input  isa_pkg::byte_t       i_din,
	output isa_pkg::byte_t       o_ir,
	output isa_pkg::addr_t       o_addr,
	output isa_pkg::byte_t       o_dout
);
	import isa_pkg::*;
	import bus_pkg::*;

	addr_t pc_q;
	addr_t addr_q; // address latch after T1
	addr_t addr_sel;
	addr_t hl;
	byte_t ir_q;
	byte_t tmp_q; // data latch for both directions
	byte_t rdata;
	byte_t acc;
	byte_t alu_b;
	byte_t alu_res;
	byte_t wdata;
	logic  cy;
	logic  alu_cy;
	logic  imm; // second cycle reads the byte after the opcode
	logic  is_alu;
	logic  pc_inc;
	logic  we;
	logic  cy_we;

	assign imm      = (i_ctrl.cls == MVI) || (i_ctrl.cls == ALU_I);
	assign is_alu   = i_ctrl.cls inside {ALU_R, ALU_M, ALU_I};
	assign pc_inc   = (i_state == T2) && (i_kind == OF || (i_kind == MR && imm));
	assign addr_sel = (i_kind == OF || imm) ? pc_q : hl;
	assign o_addr   = (i_state == T1) ? addr_sel : addr_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			pc_q <= 16'h0000;
		else if (pc_inc)
			pc_q <= pc_q + 16'd1;
	end

	always_ff @(posedge clk) begin
		if (i_state == T1)
			addr_q <= addr_sel;
		if (i_ir_load)
			ir_q <= i_din;
		if (i_state == T1 && i_kind == MW)
			tmp_q <= rdata; // MOV M,r source
		else if (i_state == T3 && i_kind == MR)
			tmp_q <= i_din;
	end

	// write-back
	assign alu_b = (i_ctrl.cls == ALU_R) ? rdata : i_din;
	assign wdata = is_alu ? alu_res : ((i_ctrl.cls == MOV_RR) ? rdata : i_din);
	assign we    = i_exec && ((is_alu && i_ctrl.op != CMP) ||
		i_ctrl.cls inside {MOV_RR, MOV_RM, MVI});
	assign cy_we = i_exec && is_alu;

	reg_file u_regs (
		.clk    (clk),
		.rst    (rst),
		.i_we   (we),
		.i_wsel (i_ctrl.dst),
		.i_wdata(wdata),
		.i_cy_we(cy_we),
		.i_cy   (alu_cy),
		.i_rsel (i_ctrl.src),
		.o_rdata(rdata),
		.o_acc  (acc),
		.o_hl   (hl),
		.o_cy   (cy)
	);

	alu u_alu (
		.i_op (i_ctrl.op),
		.i_a  (acc),
		.i_b  (alu_b),
		.i_cy (cy),
		.o_res(alu_res),
		.o_cy (alu_cy)
	);

	assign o_ir   = ir_q;
	assign o_dout = tmp_q;

	a_exec_legal: assert property (@(posedge clk) disable iff (rst)
		i_exec |-> i_ctrl.cls != ILLEGAL);

endmodule

`default_nettype wire

// ==== hdl/instr_decode.sv ====
`default_nettype none

module instr_decode (
	input  isa_pkg::byte_t       i_ir,
	output isa_pkg::ctrl_word_t  o_ctrl,
	output logic                 o_second,
	output bus_pkg::cycle_kind_t o_second_kind,
	output logic                 o_halt
);
	import isa_pkg::*;
	import bus_pkg::*;

	logic [1:0] grp; // opcode group
	reg_code_t  mid; // ddd or alu op
	reg_code_t  low; // sss

	assign grp = i_ir[7:6];
	assign mid = i_ir[5:3];
	assign low = i_ir[2:0];

	always_comb begin
		o_ctrl.cls = ILLEGAL;
		o_ctrl.op  = ADD;
		o_ctrl.dst = mid;
		o_ctrl.src = low;
		case (grp)
			GRP_TXA: begin
				if (i_ir == OPC_NOP)
					o_ctrl.cls = NOP;
				else if (low == LOW_IMM && mid != REG_M) // no MVI M
					o_ctrl.cls = MVI;
			end
			GRP_MOV: begin
				if (i_ir == OPC_HLT)
					o_ctrl.cls = HLT;
				else if (mid == REG_M)
					o_ctrl.cls = MOV_MR;
				else if (low == REG_M)
					o_ctrl.cls = MOV_RM;
				else
					o_ctrl.cls = MOV_RR;
			end
			GRP_ALU: begin
				if (low == REG_M)
					o_ctrl.cls = ALU_M;
				else
					o_ctrl.cls = ALU_R;
				o_ctrl.op  = alu_op_t'(mid);
				o_ctrl.dst = REG_A;
			end
			default: begin
				if (low == LOW_IMM) begin // ADI .. CPI
					o_ctrl.cls = ALU_I;
					o_ctrl.op  = alu_op_t'(mid);
					o_ctrl.dst = REG_A;
				end
			end
		endcase
	end

	// second machine cycle plan
	always_comb begin
		o_second      = 1'b0;
		o_second_kind = MR;
		case (o_ctrl.cls)
			MOV_RM, MVI, ALU_M, ALU_I: o_second = 1'b1;
			MOV_MR: begin
				o_second      = 1'b1;
				o_second_kind = MW;
			end
			default: o_second = 1'b0;
		endcase
	end

	assign o_halt = (o_ctrl.cls == HLT);

endmodule

`default_nettype wire

// ==== hdl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] addr_t;
	typedef logic [2:0]  reg_code_t; // 8085 register field

	localparam reg_code_t REG_B = 3'd0;
	localparam reg_code_t REG_C = 3'd1;
	localparam reg_code_t REG_D = 3'd2;
	localparam reg_code_t REG_E = 3'd3;
	localparam reg_code_t REG_H = 3'd4;
	localparam reg_code_t REG_L = 3'd5;
	localparam reg_code_t REG_M = 3'd6; // memory at HL
	localparam reg_code_t REG_A = 3'd7;

	typedef enum logic [2:0] {ADD, ADC, SUB, SBB, ANA, XRA, ORA, CMP} alu_op_t;

	typedef enum logic [3:0] {
		NOP, MOV_RR, MOV_RM, MOV_MR, MVI, ALU_R, ALU_M, ALU_I, HLT, ILLEGAL
	} instr_class_t;

	typedef struct packed {
		instr_class_t cls;
		alu_op_t      op;
		reg_code_t    dst;
		reg_code_t    src;
	} ctrl_word_t;

	localparam byte_t OPC_HLT = 8'h76;
	localparam byte_t OPC_NOP = 8'h00;
	localparam logic [2:0] LOW_IMM = 3'b110; // low field of MVI and ALU immediates

	// top two opcode bits
	localparam logic [1:0] GRP_TXA = 2'b00; // transfer and arithmetic
	localparam logic [1:0] GRP_MOV = 2'b01; // register moves and halt
	localparam logic [1:0] GRP_ALU = 2'b10; // alu on register or M
	localparam logic [1:0] GRP_SIC = 2'b11; // stack, i/o, control, immediates

endpackage

`default_nettype wire

// ==== hdl/reg_file.sv ====
`default_nettype none

module reg_file (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_we,
	input  isa_pkg::reg_code_t i_wsel,
	input  isa_pkg::byte_t     i_wdata,
	input  logic               i_cy_we,
	input  logic               i_cy,
	input  isa_pkg::reg_code_t i_rsel,
	output isa_pkg::byte_t     o_rdata,
	output isa_pkg::byte_t     o_acc,
	output isa_pkg::addr_t     o_hl,
	output logic               o_cy
);
	import isa_pkg::*;

	byte_t r_b;
	byte_t r_c;
	byte_t r_d;
	byte_t r_e;
	byte_t r_h;
	byte_t r_l;
	byte_t r_a;
	logic  cy_q;

	always_ff @(posedge clk) begin
		if (i_we) begin
			case (i_wsel)
				REG_B: r_b <= i_wdata;
				REG_C: r_c <= i_wdata;
				REG_D: r_d <= i_wdata;
				REG_E: r_e <= i_wdata;
				REG_H: r_h <= i_wdata;
				REG_L: r_l <= i_wdata;
				REG_A: r_a <= i_wdata;
				default: ; // M lives on the bus
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			cy_q <= 1'b0;
		else if (i_cy_we)
			cy_q <= i_cy;
	end

	always_comb begin
		case (i_rsel)
			REG_B: o_rdata = r_b;
			REG_C: o_rdata = r_c;
			REG_D: o_rdata = r_d;
			REG_E: o_rdata = r_e;
			REG_H: o_rdata = r_h;
			REG_L: o_rdata = r_l;
			REG_A: o_rdata = r_a;
			default: o_rdata = 8'h00;
		endcase
	end

	assign o_acc = r_a;
	assign o_hl  = {r_h, r_l}; // memory pointer
	assign o_cy  = cy_q;

endmodule

`default_nettype wire

// ==== list.f ====
hdl/isa_pkg.sv
hdl/bus_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/datapath.sv
hdl/instr_decode.sv
hdl/bus_cycle_ctrl.sv
hdl/cpu85_top.sv
testbench/mem_model.sv
testbench/tb_cpu85.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_cpu85 -f list.f &&
./obj_dir/Vtb_cpu85 | tee /dev/stderr | grep -q "Finished with no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== testbench/mem_model.sv ====
`default_nettype none

module mem_model (
	input  logic           clk,
	input  logic           i_ale,
	input  logic           i_rd_n,
	input  logic           i_wr_n,
	input  isa_pkg::addr_t i_addr,
	input  isa_pkg::byte_t i_data,
	output isa_pkg::byte_t o_data,
	output logic           o_ready
);
	import isa_pkg::*;

	byte_t       mem [0:65535];
	int unsigned wait_cnt; // wait states left in this cycle

	initial begin
		o_data   = 8'h00;
		o_ready  = 1'b1;
		wait_cnt = 0;
		void'($urandom(32'h201a));
		forever begin
			@(negedge clk);
			if (i_ale)
				wait_cnt = $urandom % 4; // 0 to 3 wait states
			if (!i_rd_n || !i_wr_n) begin
				o_ready = (wait_cnt == 0);
				if (wait_cnt != 0)
					wait_cnt--;
			end
			if (!i_rd_n)
				o_data = mem[i_addr];
			if (!i_wr_n)
				mem[i_addr] = i_data; // same byte on every clock of the strobe
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_cpu85.sv ====
`default_nettype none

module tb_cpu85;
	import isa_pkg::*;
	import bus_pkg::*;

	typedef struct packed {
		alu_op_t op;
		byte_t   a;
		byte_t   b;
		logic    cy; // carry set up before the operation
		byte_t   res;
	} row_t;

	typedef struct packed {
		bus_stat_t  stat;
		addr_t      addr;
		byte_t      data; // write cycles only
		logic [7:0] prog;
	} cycle_t;

	logic      clk;
	logic      rst;
	logic      ready;
	byte_t     din;
	addr_t     addr;
	byte_t     dout;
	bus_stat_t stat;
	logic      ale;
	logic      rd_n;
	logic      wr_n;

	row_t   rows [0:7];
	cycle_t exp_q [$]; // bus cycles in program order
	cycle_t cur;
	addr_t  pc;
	int     prog_n;
	int     n_checks;
	int     n_errors;
	int     n_writes;
	logic   wr_seen;

	cpu85_top dut (
		.clk    (clk),
		.rst    (rst),
		.i_ready(ready),
		.i_din  (din),
		.o_addr (addr),
		.o_dout (dout),
		.o_stat (stat),
		.o_ale  (ale),
		.o_rd_n (rd_n),
		.o_wr_n (wr_n)
	);

	mem_model u_mem (
		.clk    (clk),
		.i_ale  (ale),
		.i_rd_n (rd_n),
		.i_wr_n (wr_n),
		.i_addr (addr),
		.i_data (dout),
		.o_data (din),
		.o_ready(ready)
	);

	always #20 clk = ~clk;

	//----------------------------------------------------------------------
	// checks
	//----------------------------------------------------------------------
	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("Error: %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("Error: %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_stat(input string name, input bus_stat_t exp, input bus_stat_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("Error: %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic report_fault(input string what);
		n_errors++;
		$display("%s", what);
	endtask

	//----------------------------------------------------------------------
	// program builder
	//----------------------------------------------------------------------
	task automatic put_op(input byte_t opc);
		u_mem.mem[pc] = opc;
		exp_q.push_back(cycle_t'{STAT_OF, pc, 8'h00, 8'(prog_n)});
		pc++;
	endtask

	task automatic put_imm(input byte_t val);
		u_mem.mem[pc] = val;
		exp_q.push_back(cycle_t'{STAT_MR, pc, 8'h00, 8'(prog_n)});
		pc++;
	endtask

	task automatic build_program(input row_t r, input int form);
		addr_t hl;
		hl = 16'h8000 + 16'(prog_n); // result byte of this program
		pc = 16'(prog_n * 16);
		put_op({GRP_TXA, REG_H, LOW_IMM});
		put_imm(hl[15:8]);
		put_op({GRP_TXA, REG_L, LOW_IMM});
		put_imm(hl[7:0]);
		put_op({GRP_TXA, REG_A, LOW_IMM});
		put_imm(8'hFF);
		if (r.cy) begin
			put_op({GRP_SIC, 3'(ADD), LOW_IMM}); // ADI 01 wraps and sets carry
			put_imm(8'h01);
		end else begin
			put_op({GRP_ALU, 3'(ORA), REG_A}); // ORA A clears carry
		end
		put_op({GRP_TXA, REG_A, LOW_IMM});
		put_imm(r.a);
		put_op({GRP_TXA, REG_B, LOW_IMM});
		put_imm(r.b);
		case (form)
			0: put_op({GRP_ALU, 3'(r.op), REG_B});
			1: begin
				u_mem.mem[hl] = r.b; // operand read through HL
				put_op({GRP_ALU, 3'(r.op), REG_M});
				exp_q.push_back(cycle_t'{STAT_MR, hl, 8'h00, 8'(prog_n)});
			end
			default: begin
				put_op({GRP_SIC, 3'(r.op), LOW_IMM});
				put_imm(r.b);
			end
		endcase
		put_op({GRP_MOV, REG_M, REG_A}); // MOV M,A
		exp_q.push_back(cycle_t'{STAT_MW, hl, r.res, 8'(prog_n)});
		while (pc[3:0] != 4'h0)
			put_op(OPC_NOP);
		prog_n++;
	endtask

	//----------------------------------------------------------------------
	// bus monitor
	//----------------------------------------------------------------------
	always @(negedge clk) begin
		if (!rst) begin
			if (ale) begin
				if (exp_q.size() == 0) begin
					report_fault($sformatf("bus cycle at %h after the program ended", addr));
				end else begin
					cur = exp_q.pop_front();
					check_stat($sformatf("prog %0d cycle status", cur.prog), cur.stat, stat);
					check_addr($sformatf("prog %0d cycle address", cur.prog), cur.addr, addr);
				end
			end
			if (!wr_n && !wr_seen) begin
				n_writes++;
				check_stat($sformatf("prog %0d write status", cur.prog), STAT_MW, stat);
				check_byte($sformatf("prog %0d write data", cur.prog), cur.data, dout);
				check_addr($sformatf("prog %0d write address", cur.prog), cur.addr, addr);
			end
			wr_seen = !wr_n;
		end
	end

	initial begin
		int row;
		int pass;
		int i;
		clk      = 1'b0;
		rst      = 1'b1;
		wr_seen  = 1'b0;
		n_checks = 0;
		n_errors = 0;
		n_writes = 0;
		prog_n   = 0;
		rows[0] = '{ADD, 8'h3C, 8'h5A, 1'b0, 8'h96};
		rows[1] = '{ADC, 8'h7F, 8'h80, 1'b1, 8'h00};
		rows[2] = '{SUB, 8'h20, 8'h31, 1'b0, 8'hEF};
		rows[3] = '{SBB, 8'h50, 8'h10, 1'b1, 8'h3F};
		rows[4] = '{ANA, 8'hF0, 8'h3C, 1'b0, 8'h30};
		rows[5] = '{XRA, 8'hA5, 8'hFF, 1'b1, 8'h5A};
		rows[6] = '{ORA, 8'h12, 8'h40, 1'b1, 8'h52};
		rows[7] = '{CMP, 8'h66, 8'h99, 1'b1, 8'h66}; // A unchanged
		// register, M and immediate forms rotate with the row
		for (pass = 0; pass < 3; pass++) begin
			for (row = 0; row < 8; row++)
				build_program(rows[row], (row + pass) % 3);
		end
		put_op(OPC_HLT);

		repeat (8) begin
			@(negedge clk);
			if (!rd_n || !wr_n || ale)
				report_fault("bus control pin active during reset");
		end
		rst = 1'b0;

		i = 0;
		while (!ale && i < 20) begin
			if (!rd_n || !wr_n)
				report_fault("strobe low before the first T1");
			@(negedge clk);
			i++;
		end
		if (!ale)
			report_fault("timeout waiting for the first T1 after reset");
		check_stat("first cycle status", STAT_OF, stat);
		check_addr("first cycle address", 16'h0000, addr);

		i = 0;
		while (exp_q.size() != 0 && i < 20000) begin
			@(negedge clk);
			i++;
		end
		if (exp_q.size() != 0)
			report_fault($sformatf("timeout with %0d bus cycles never run", exp_q.size()));

		i = 0;
		while (stat !== STAT_HALT && i < 50) begin
			@(negedge clk);
			i++;
		end
		check_stat("halt status", STAT_HALT, stat);
		for (i = 0; i < 50; i++) begin
			@(negedge clk);
			if (!rd_n || !wr_n || ale)
				report_fault("bus activity after HLT");
		end
		if (n_writes != prog_n)
			report_fault($sformatf("%0d write strobes seen for %0d programs", n_writes, prog_n));

		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire
